// ==== source/amber_ctrl_pkg.sv ====
package amber_ctrl_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int addr_w    = 48;
    localparam int data_w    = 24;
    localparam int csr_idx_w = 8;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;

    // ----------------------------------------------------------------------
    // PCC reset window
    // ----------------------------------------------------------------------
    // Default window is 4K BAUs from address 0
    localparam addr_t pcc_len_rst = addr_t'(4096);

    localparam int    pcc_perm_x_bit = 2;
    // Execute only
    localparam data_t pcc_perms_rst  = data_t'(1) << pcc_perm_x_bit;

    // ----------------------------------------------------------------------
    // CSR indices and trap kinds
    // ----------------------------------------------------------------------
    typedef enum logic [csr_idx_w-1:0] {
        csr_status      = 8'h00,
        csr_pcc_base_lo = 8'h10,
        csr_pcc_base_hi = 8'h11,
        csr_pcc_len_lo  = 8'h12,
        csr_pcc_len_hi  = 8'h13,
        csr_pcc_cur_lo  = 8'h14,
        csr_pcc_cur_hi  = 8'h15,
        csr_pcc_perms   = 8'h16,
        csr_pcc_attr    = 8'h17,
        csr_pcc_tag     = 8'h18
    } csr_idx_e;

    // SYSCALL enters kernel, KRET returns to user
    typedef enum logic {
        trap_syscall = 1'b0,
        trap_kret    = 1'b1
    } trap_kind_e;

endpackage

// ==== source/pcc_fetch.sv ====
module pcc_fetch (
    input  logic                          iw_clk,
    input  logic                          iw_rst,

    input  logic                          csr_we,
    input  amber_ctrl_pkg::csr_idx_e      csr_addr,
    input  amber_ctrl_pkg::data_t         csr_wdata,

    input  logic                          branch_taken,
    input  amber_ctrl_pkg::addr_t         branch_pc,
    input  logic                          stall,

    output amber_ctrl_pkg::addr_t         pc,
    output logic                          fetch_fault,

    output amber_ctrl_pkg::addr_t         pcc_base,
    output amber_ctrl_pkg::addr_t         pcc_len,
    output amber_ctrl_pkg::addr_t         pcc_cur,
    output amber_ctrl_pkg::data_t         pcc_perms,
    output amber_ctrl_pkg::data_t         pcc_attr,
    output logic                          pcc_tag
);

    localparam int lo_hi = amber_ctrl_pkg::data_w - 1;
    localparam int hi_lo = amber_ctrl_pkg::data_w;
    localparam int hi_hi = amber_ctrl_pkg::addr_w - 1;

    amber_ctrl_pkg::addr_t pcc_end;
    logic                  in_bounds;
    logic                  fetch_ok;

    // ----------------------------------------------------------------------
    // Fetch permission
    // ----------------------------------------------------------------------
    // End of window wraps at 48 bits like the core datapath
    assign pcc_end     = pcc_base + pcc_len;
    assign in_bounds   = (pc >= pcc_base) && (pc < pcc_end);
    assign fetch_ok    = pcc_tag && pcc_perms[amber_ctrl_pkg::pcc_perm_x_bit] && in_bounds;
    assign fetch_fault = !fetch_ok;

    // ----------------------------------------------------------------------
    // Fetch PC
    // ----------------------------------------------------------------------
    // Redirect beats stall; a PCC violation holds the PC
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_pc;
        end else if (!stall && fetch_ok) begin
            pc <= pc + amber_ctrl_pkg::addr_t'(1);
        end
    end

    // ----------------------------------------------------------------------
    // PCC window
    // ----------------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pcc_base  <= '0;
            pcc_len   <= amber_ctrl_pkg::pcc_len_rst;
            pcc_cur   <= '0;
            pcc_perms <= amber_ctrl_pkg::pcc_perms_rst;
            pcc_attr  <= '0;
            pcc_tag   <= 1'b1;
        end else begin
            // Cursor follows the PC unless software writes a half of it
            pcc_cur <= pc;
            if (csr_we) begin
                case (csr_addr)
                    amber_ctrl_pkg::csr_pcc_base_lo: pcc_base[lo_hi:0]     <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_base_hi: pcc_base[hi_hi:hi_lo] <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_len_lo:  pcc_len[lo_hi:0]      <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_len_hi:  pcc_len[hi_hi:hi_lo]  <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_cur_lo:  pcc_cur[lo_hi:0]      <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_cur_hi:  pcc_cur[hi_hi:hi_lo]  <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_perms:   pcc_perms             <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_attr:    pcc_attr              <= csr_wdata;
                    amber_ctrl_pkg::csr_pcc_tag:     pcc_tag               <= csr_wdata[0];
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/priv_mode.sv ====
module priv_mode (
    input  logic                          iw_clk,
    input  logic                          iw_rst,

    input  logic                          csr_we,
    input  amber_ctrl_pkg::csr_idx_e      csr_addr,
    input  amber_ctrl_pkg::data_t         csr_wdata,

    input  logic                          trap_taken,
    input  amber_ctrl_pkg::trap_kind_e    trap_kind,

    output logic                          mode_kernel
);

    logic status_wr;

    // Only kernel code may rewrite the mode through STATUS
    assign status_wr = csr_we && (csr_addr == amber_ctrl_pkg::csr_status) && mode_kernel;

    // 1 = kernel, 0 = user
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            mode_kernel <= 1'b1;
        end else if (trap_taken) begin
            // Trap entry and return take priority over a STATUS write
            case (trap_kind)
                amber_ctrl_pkg::trap_syscall: mode_kernel <= 1'b1;
                amber_ctrl_pkg::trap_kret:    mode_kernel <= 1'b0;
                default:                      mode_kernel <= mode_kernel;
            endcase
        end else if (status_wr) begin
            mode_kernel <= csr_wdata[0];
        end
    end

endmodule

// ==== source/csr_read_port.sv ====
module csr_read_port (
    input  logic                          iw_clk,
    input  logic                          iw_rst,

    input  logic                          rd_en,
    input  amber_ctrl_pkg::csr_idx_e      rd_addr,

    input  amber_ctrl_pkg::addr_t         pcc_base,
    input  amber_ctrl_pkg::addr_t         pcc_len,
    input  amber_ctrl_pkg::addr_t         pcc_cur,
    input  amber_ctrl_pkg::data_t         pcc_perms,
    input  amber_ctrl_pkg::data_t         pcc_attr,
    input  logic                          pcc_tag,
    input  logic                          mode_kernel,

    output logic                          rd_valid,
    output amber_ctrl_pkg::data_t         rd_data
);

    localparam int lo_hi = amber_ctrl_pkg::data_w - 1;
    localparam int hi_lo = amber_ctrl_pkg::data_w;
    localparam int hi_hi = amber_ctrl_pkg::addr_w - 1;

    amber_ctrl_pkg::data_t rd_sel;

    // ----------------------------------------------------------------------
    // Read select
    // ----------------------------------------------------------------------
    // STATUS shows the live mode bit
    always_comb begin
        rd_sel = '0;
        case (rd_addr)
            amber_ctrl_pkg::csr_status:      rd_sel = {{lo_hi{1'b0}}, mode_kernel};
            amber_ctrl_pkg::csr_pcc_base_lo: rd_sel = pcc_base[lo_hi:0];
            amber_ctrl_pkg::csr_pcc_base_hi: rd_sel = pcc_base[hi_hi:hi_lo];
            amber_ctrl_pkg::csr_pcc_len_lo:  rd_sel = pcc_len[lo_hi:0];
            amber_ctrl_pkg::csr_pcc_len_hi:  rd_sel = pcc_len[hi_hi:hi_lo];
            amber_ctrl_pkg::csr_pcc_cur_lo:  rd_sel = pcc_cur[lo_hi:0];
            amber_ctrl_pkg::csr_pcc_cur_hi:  rd_sel = pcc_cur[hi_hi:hi_lo];
            amber_ctrl_pkg::csr_pcc_perms:   rd_sel = pcc_perms;
            amber_ctrl_pkg::csr_pcc_attr:    rd_sel = pcc_attr;
            amber_ctrl_pkg::csr_pcc_tag:     rd_sel = {{lo_hi{1'b0}}, pcc_tag};
            // Unmapped indices read as zero
            default:                         rd_sel = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Read register
    // ----------------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                rd_data <= rd_sel;
            end
        end
    end

endmodule

// ==== source/amber_ctrl.sv ====
module amber_ctrl (
    input  logic                          iw_clk,
    input  logic                          iw_rst,

    // Retired CSR writes from writeback
    input  logic                          csr_we,
    input  amber_ctrl_pkg::csr_idx_e      csr_addr,
    input  amber_ctrl_pkg::data_t         csr_wdata,

    input  logic                          trap_taken,
    input  amber_ctrl_pkg::trap_kind_e    trap_kind,

    input  logic                          branch_taken,
    input  amber_ctrl_pkg::addr_t         branch_pc,
    // Combined hazard and cache stall
    input  logic                          stall,

    input  logic                          rd_en,
    input  amber_ctrl_pkg::csr_idx_e      rd_addr,

    output amber_ctrl_pkg::addr_t         pc,
    output logic                          fetch_fault,
    output logic                          mode_kernel,
    output logic                          rd_valid,
    output amber_ctrl_pkg::data_t         rd_data
);

    amber_ctrl_pkg::addr_t pcc_base;
    amber_ctrl_pkg::addr_t pcc_len;
    amber_ctrl_pkg::addr_t pcc_cur;
    amber_ctrl_pkg::data_t pcc_perms;
    amber_ctrl_pkg::data_t pcc_attr;
    logic                  pcc_tag;

    pcc_fetch u_pcc_fetch (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .csr_we       (csr_we),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .stall        (stall),
        .pc           (pc),
        .fetch_fault  (fetch_fault),
        .pcc_base     (pcc_base),
        .pcc_len      (pcc_len),
        .pcc_cur      (pcc_cur),
        .pcc_perms    (pcc_perms),
        .pcc_attr     (pcc_attr),
        .pcc_tag      (pcc_tag)
    );

    priv_mode u_priv_mode (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .csr_we       (csr_we),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .trap_taken   (trap_taken),
        .trap_kind    (trap_kind),
        .mode_kernel  (mode_kernel)
    );

    csr_read_port u_csr_read_port (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .pcc_base     (pcc_base),
        .pcc_len      (pcc_len),
        .pcc_cur      (pcc_cur),
        .pcc_perms    (pcc_perms),
        .pcc_attr     (pcc_attr),
        .pcc_tag      (pcc_tag),
        .mode_kernel  (mode_kernel),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

endmodule

// ==== test/amber_ctrl_model.svh ====
`ifndef AMBER_CTRL_MODEL_SVH
`define AMBER_CTRL_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model state
// ----------------------------------------------------------------------
amber_ctrl_pkg::addr_t m_pc;
amber_ctrl_pkg::addr_t m_base;
amber_ctrl_pkg::addr_t m_len;
amber_ctrl_pkg::addr_t m_cur;
amber_ctrl_pkg::data_t m_perms;
amber_ctrl_pkg::data_t m_attr;
logic                  m_tag;
logic                  m_mode;
logic                  m_rd_valid;
amber_ctrl_pkg::data_t m_rd_data;

function automatic void model_reset();
    m_pc       = '0;
    m_base     = '0;
    m_len      = amber_ctrl_pkg::pcc_len_rst;
    m_cur      = '0;
    m_perms    = amber_ctrl_pkg::pcc_perms_rst;
    m_attr     = '0;
    m_tag      = 1'b1;
    m_mode     = 1'b1;
    m_rd_valid = 1'b0;
    m_rd_data  = '0;
endfunction

// Tag, X bit and PC inside [base, base + len)
function automatic logic model_fetch_ok();
    amber_ctrl_pkg::addr_t lim;
    lim = m_base + m_len;
    return m_tag && m_perms[amber_ctrl_pkg::pcc_perm_x_bit] && (m_pc >= m_base) && (m_pc < lim);
endfunction

function automatic amber_ctrl_pkg::data_t model_read(input logic [7:0] idx);
    case (idx)
        amber_ctrl_pkg::csr_status:      return amber_ctrl_pkg::data_t'(m_mode);
        amber_ctrl_pkg::csr_pcc_base_lo: return m_base[23:0];
        amber_ctrl_pkg::csr_pcc_base_hi: return m_base[47:24];
        amber_ctrl_pkg::csr_pcc_len_lo:  return m_len[23:0];
        amber_ctrl_pkg::csr_pcc_len_hi:  return m_len[47:24];
        amber_ctrl_pkg::csr_pcc_cur_lo:  return m_cur[23:0];
        amber_ctrl_pkg::csr_pcc_cur_hi:  return m_cur[47:24];
        amber_ctrl_pkg::csr_pcc_perms:   return m_perms;
        amber_ctrl_pkg::csr_pcc_attr:    return m_attr;
        amber_ctrl_pkg::csr_pcc_tag:     return amber_ctrl_pkg::data_t'(m_tag);
        default:                         return '0;
    endcase
endfunction

// One rising edge; everything is computed from the state before the edge
function automatic void model_step(
    input logic                  we,
    input logic [7:0]            addr,
    input amber_ctrl_pkg::data_t wdata,
    input logic                  trap,
    input logic                  kind,
    input logic                  br,
    input amber_ctrl_pkg::addr_t br_pc,
    input logic                  stl,
    input logic                  ren,
    input logic [7:0]            raddr
);
    amber_ctrl_pkg::addr_t n_pc;
    n_pc = m_pc;
    if (br)
        n_pc = br_pc;
    else if (!stl && model_fetch_ok())
        n_pc = m_pc + 1;
    m_rd_valid = ren;
    if (ren)
        m_rd_data = model_read(raddr);
    if (trap)
        m_mode = (kind == amber_ctrl_pkg::trap_syscall);
    else if (we && (addr == amber_ctrl_pkg::csr_status) && m_mode)
        m_mode = wdata[0];
    m_cur = m_pc;
    if (we) begin
        case (addr)
            amber_ctrl_pkg::csr_pcc_base_lo: m_base[23:0]  = wdata;
            amber_ctrl_pkg::csr_pcc_base_hi: m_base[47:24] = wdata;
            amber_ctrl_pkg::csr_pcc_len_lo:  m_len[23:0]   = wdata;
            amber_ctrl_pkg::csr_pcc_len_hi:  m_len[47:24]  = wdata;
            amber_ctrl_pkg::csr_pcc_cur_lo:  m_cur[23:0]   = wdata;
            amber_ctrl_pkg::csr_pcc_cur_hi:  m_cur[47:24]  = wdata;
            amber_ctrl_pkg::csr_pcc_perms:   m_perms       = wdata;
            amber_ctrl_pkg::csr_pcc_attr:    m_attr        = wdata;
            amber_ctrl_pkg::csr_pcc_tag:     m_tag         = wdata[0];
            default: begin
            end
        endcase
    end
    m_pc = n_pc;
endfunction

`endif

// ==== test/amber_ctrl_tb.sv ====
module amber_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int rd_timeout    = 8;
    localparam int fault_timeout = 20;
    localparam int random_cycles = 2000;

    logic                       iw_clk;
    logic                       iw_rst;
    logic                       csr_we;
    amber_ctrl_pkg::csr_idx_e   csr_addr;
    amber_ctrl_pkg::data_t      csr_wdata;
    logic                       trap_taken;
    amber_ctrl_pkg::trap_kind_e trap_kind;
    logic                       branch_taken;
    amber_ctrl_pkg::addr_t      branch_pc;
    logic                       stall;
    logic                       rd_en;
    amber_ctrl_pkg::csr_idx_e   rd_addr;
    amber_ctrl_pkg::addr_t      pc;
    logic                       fetch_fault;
    logic                       mode_kernel;
    logic                       rd_valid;
    amber_ctrl_pkg::data_t      rd_data;

    integer seed;
    int     checks;
    int     errors;
    int     test_base;

    `include "amber_ctrl_model.svh"

    amber_ctrl dut (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .csr_we       (csr_we),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .trap_taken   (trap_taken),
        .trap_kind    (trap_kind),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .stall        (stall),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .pc           (pc),
        .fetch_fault  (fetch_fault),
        .mode_kernel  (mode_kernel),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    task automatic compare_value(input string name, input logic [47:0] got,
                                 input logic [47:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // Model steps on the rising edge and outputs are compared on the falling edge
    task automatic tick();
        @(posedge iw_clk);
        model_step(csr_we, csr_addr, csr_wdata, trap_taken, trap_kind, branch_taken,
                   branch_pc, stall, rd_en, rd_addr);
        @(negedge iw_clk);
        compare_value("pc", pc, m_pc);
        compare_value("fetch_fault", fetch_fault, !model_fetch_ok());
        compare_value("mode_kernel", mode_kernel, m_mode);
        compare_value("rd_valid", rd_valid, m_rd_valid);
        if (m_rd_valid)
            compare_value("rd_data", rd_data, m_rd_data);
    endtask

    task automatic csr_write(input logic [7:0] idx, input amber_ctrl_pkg::data_t data);
        csr_we    = 1'b1;
        csr_addr  = amber_ctrl_pkg::csr_idx_e'(idx);
        csr_wdata = data;
        tick();
        csr_we    = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] idx, input amber_ctrl_pkg::data_t exp);
        int n;
        rd_en   = 1'b1;
        rd_addr = amber_ctrl_pkg::csr_idx_e'(idx);
        tick();
        rd_en   = 1'b0;
        n = 0;
        while (!rd_valid && n < rd_timeout) begin
            tick();
            n++;
        end
        if (!rd_valid) begin
            errors++;
            $display("Read of CSR %h never returned rd_valid", idx);
        end else begin
            compare_value("rd_data", rd_data, exp);
        end
    endtask

    task automatic take_trap(input logic kind);
        trap_taken = 1'b1;
        trap_kind  = amber_ctrl_pkg::trap_kind_e'(kind);
        tick();
        trap_taken = 1'b0;
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // Mostly mapped indices, some STATUS, some arbitrary
    function automatic logic [7:0] pick_index(input logic [31:0] r);
        if (r[3:0] < 4'd9)
            return 8'h10 + r[3:0];
        else if (r[3:0] < 4'd12)
            return 8'h00;
        return r[11:4];
    endfunction

    initial begin
        int                    n;
        logic [31:0]           r;
        amber_ctrl_pkg::addr_t p;
        seed         = 72121;
        checks       = 0;
        errors       = 0;
        test_base    = 0;
        iw_rst       = 1'b1;
        csr_we       = 1'b0;
        csr_addr     = amber_ctrl_pkg::csr_status;
        csr_wdata    = '0;
        trap_taken   = 1'b0;
        trap_kind    = amber_ctrl_pkg::trap_syscall;
        branch_taken = 1'b0;
        branch_pc    = '0;
        stall        = 1'b0;
        rd_en        = 1'b0;
        rd_addr      = amber_ctrl_pkg::csr_status;
        model_reset();
        repeat (5) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;

        // ------------------------------------------------------------------
        // Reset state
        // ------------------------------------------------------------------
        read_expect(amber_ctrl_pkg::csr_status, 24'd1);
        read_expect(amber_ctrl_pkg::csr_pcc_len_lo, 24'd4096);
        read_expect(amber_ctrl_pkg::csr_pcc_perms, 24'd4);
        read_expect(amber_ctrl_pkg::csr_pcc_tag, 24'd1);
        repeat (4) begin
            p = m_pc;
            tick();
            compare_value("pc", pc, p + 1);
        end
        finish_test("reset_state");

        // ------------------------------------------------------------------
        // Bounds, tag and X gating
        // ------------------------------------------------------------------
        branch_taken = 1'b1;
        branch_pc    = '0;
        csr_write(amber_ctrl_pkg::csr_pcc_len_lo, 24'd5);
        branch_taken = 1'b0;
        csr_write(amber_ctrl_pkg::csr_pcc_base_lo, 24'd0);
        n = 0;
        while (!fetch_fault && n < fault_timeout) begin
            tick();
            n++;
        end
        if (!fetch_fault) begin
            errors++;
            $display("PC never left the 5-word window, fetch_fault stayed low");
        end
        repeat (2) tick();
        compare_value("pc", pc, 48'd5);
        branch_taken = 1'b1;
        branch_pc    = 48'h20;
        csr_write(amber_ctrl_pkg::csr_pcc_len_lo, 24'd4096);
        branch_taken = 1'b0;
        csr_write(amber_ctrl_pkg::csr_pcc_tag, 24'd0);
        p = m_pc;
        tick();
        compare_value("pc", pc, p);
        compare_value("fetch_fault", fetch_fault, 1'b1);
        csr_write(amber_ctrl_pkg::csr_pcc_tag, 24'd1);
        csr_write(amber_ctrl_pkg::csr_pcc_perms, 24'd0);
        p = m_pc;
        tick();
        compare_value("pc", pc, p);
        compare_value("fetch_fault", fetch_fault, 1'b1);
        csr_write(amber_ctrl_pkg::csr_pcc_perms, 24'd4);
        finish_test("bounds_gating");

        // ------------------------------------------------------------------
        // Redirect, stall and cursor
        // ------------------------------------------------------------------
        stall = 1'b1;
        tick();
        p = m_pc;
        tick();
        compare_value("pc", pc, p);
        branch_taken = 1'b1;
        branch_pc    = 48'h100;
        tick();
        compare_value("pc", pc, 48'h100);
        branch_taken = 1'b0;
        stall        = 1'b0;
        p = m_pc;
        tick();
        read_expect(amber_ctrl_pkg::csr_pcc_cur_lo, p[23:0]);
        finish_test("redirect_stall");

        // ------------------------------------------------------------------
        // Privilege
        // ------------------------------------------------------------------
        csr_write(amber_ctrl_pkg::csr_status, 24'd0);
        compare_value("mode_kernel", mode_kernel, 1'b0);
        csr_write(amber_ctrl_pkg::csr_status, 24'd1);
        compare_value("mode_kernel", mode_kernel, 1'b0);
        take_trap(amber_ctrl_pkg::trap_syscall);
        compare_value("mode_kernel", mode_kernel, 1'b1);
        take_trap(amber_ctrl_pkg::trap_kret);
        compare_value("mode_kernel", mode_kernel, 1'b0);
        take_trap(amber_ctrl_pkg::trap_syscall);
        // Trap and STATUS write land in the same cycle
        trap_taken = 1'b1;
        trap_kind  = amber_ctrl_pkg::trap_kret;
        csr_write(amber_ctrl_pkg::csr_status, 24'd1);
        compare_value("mode_kernel", mode_kernel, 1'b0);
        take_trap(amber_ctrl_pkg::trap_syscall);
        trap_taken = 1'b1;
        trap_kind  = amber_ctrl_pkg::trap_syscall;
        csr_write(amber_ctrl_pkg::csr_status, 24'd0);
        trap_taken = 1'b0;
        compare_value("mode_kernel", mode_kernel, 1'b1);
        finish_test("privilege");

        // ------------------------------------------------------------------
        // Random mix
        // ------------------------------------------------------------------
        repeat (random_cycles) begin
            r            = $random(seed);
            csr_we       = (r[1:0] == 2'd0);
            csr_addr     = amber_ctrl_pkg::csr_idx_e'(pick_index($random(seed)));
            csr_wdata    = amber_ctrl_pkg::data_t'($random(seed));
            trap_taken   = (r[4:2] == 3'd0);
            trap_kind    = amber_ctrl_pkg::trap_kind_e'(r[5]);
            branch_taken = (r[9:6] == 4'd0);
            branch_pc    = {36'd0, r[21:10]};
            stall        = (r[23:22] == 2'd0);
            rd_en        = r[24];
            rd_addr      = amber_ctrl_pkg::csr_idx_e'(pick_index($random(seed)));
            tick();
        end
        csr_we       = 1'b0;
        trap_taken   = 1'b0;
        branch_taken = 1'b0;
        stall        = 1'b0;
        rd_en        = 1'b0;
        finish_test("random_mix");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== amber_ctrl.f ====
+incdir+test
source/amber_ctrl_pkg.sv
source/pcc_fetch.sv
source/priv_mode.sv
source/csr_read_port.sv
source/amber_ctrl.sv
test/amber_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: amber_ctrl

sources:
  - files:
      - source/amber_ctrl_pkg.sv
      - source/pcc_fetch.sv
      - source/priv_mode.sv
      - source/csr_read_port.sv
      - source/amber_ctrl.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/amber_ctrl_tb.sv
